//--- project.f
+incdir+src
+incdir+verif
src/isaPkg.sv
src/ctrlPkg.sv
src/creditFifo.sv
src/fieldDecoder.sv
src/branchResolver.sv
src/ctrlEgress.sv
src/decodeTop.sv
verif/decodeTb.sv

//--- run.sh
#!/usr/bin/env bash

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal -f project.f --top-module decodeTb -o decodeSim
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/decodeSim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "Verification failed" sim.log; then
	exit 1
fi
if ! grep -q "Verification passed" sim.log; then
	echo "Simulation ended without a result"
	exit 1
fi
exit 0

//--- verif/decodeModel.svh
`ifndef DECODE_MODEL_SVH
`define DECODE_MODEL_SVH

// Expected control record, one field per DUT output
typedef struct packed {
	logic rfWr;
	logic [1:0] dstSel;
	logic [2:0] wbSel;
	logic [1:0] extOp;
	logic [4:0] aluOp;
	logic shamtSel;
	logic dmRd;
	logic dmWr;
	logic [2:0] dmSel;
	logic [1:0] npcOp;
	logic likelyFlush;
	logic riExc;
} expRec_t;

// ALU operation of a register form, aluNone when the funct is not kept
function automatic logic [4:0] functAlu(input logic [5:0] fn);
	case (fn)
		fnAdd: return aluAdd;
		fnAddu: return aluAddu;
		fnSub: return aluSub;
		fnSubu: return aluSubu;
		fnAnd: return aluAnd;
		fnOr: return aluOr;
		fnXor: return aluXor;
		fnNor: return aluNor;
		fnSlt: return aluSlt;
		fnSltu: return aluSltu;
		fnSll, fnSllv: return aluSll;
		fnSrl, fnSrlv: return aluSrl;
		fnSra, fnSrav: return aluSra;
		default: return aluNone;
	endcase
endfunction

function automatic expRec_t decodeRef(input logic [31:0] w, input logic eq,
	input logic [1:0] sign);
	expRec_t r;
	logic [5:0] op;
	logic [5:0] fn;
	logic [4:0] rt;
	logic isBranch;
	logic likely;
	logic taken;
	op = w[31:26];
	fn = w[5:0];
	rt = w[20:16];
	r = '0;
	r.dstSel = dstRt;
	r.wbSel = wbAlu;
	r.aluOp = aluNone;
	r.dmSel = dmLoadWord;  // Idle memory size
	isBranch = 1'b0;
	likely = 1'b0;
	taken = 1'b0;
	case (op)
		opSpecial: begin
			r.dstSel = dstRd;
			if (fn == fnJr) begin
				r.npcOp = npcJumpReg;
			end else if (fn == fnJalr) begin
				r.rfWr = 1'b1;
				r.wbSel = wbLink;
				r.npcOp = npcJumpReg;
			end else if (functAlu(fn) != aluNone) begin
				r.rfWr = 1'b1;
				r.aluOp = functAlu(fn);
				r.shamtSel = (fn[5:2] == 4'b0000);  // SLL, SRL, SRA
			end else begin
				r.dstSel = dstRt;
				r.riExc = 1'b1;
			end
		end
		opRegimm: begin
			if (rt[3:2] == 2'b00) begin  // The eight kept selectors
				isBranch = 1'b1;
				taken = rt[0] ? (sign != 2'b10) : (sign == 2'b10);
				likely = rt[1];
				r.rfWr = rt[4];
				r.dstSel = dstR31;
				r.wbSel = wbLink;
			end else begin
				r.riExc = 1'b1;
			end
		end
		opJ: r.npcOp = npcJump;
		opJal: begin
			r.rfWr = 1'b1;
			r.dstSel = dstR31;
			r.wbSel = wbLink;
			r.npcOp = npcJump;
		end
		opBeq, opBne, opBeql, opBnel: begin
			isBranch = 1'b1;
			taken = eq ^ op[0];
			likely = op[4];
		end
		opBlez, opBgtz, opBlezl, opBgtzl: begin
			isBranch = 1'b1;
			taken = op[0] ? (sign == 2'b01) : (sign != 2'b01);
			likely = op[4];
			if (op[4] && rt != 5'd0) begin
				// Likely form with rt set is reserved and never taken
				r.riExc = 1'b1;
				taken = 1'b0;
			end
		end
		opAddi, opAddiu, opSlti, opSltiu, opAndi, opOri, opXori: begin
			r.rfWr = 1'b1;
			r.extOp = op[2] ? extZero : extSign;  // Logic ops zero extend
			case (op[2:0])
				3'd0: r.aluOp = aluAdd;
				3'd1: r.aluOp = aluAddu;
				3'd2: r.aluOp = aluSlt;
				3'd3: r.aluOp = aluSltu;
				3'd4: r.aluOp = aluAnd;
				3'd5: r.aluOp = aluOr;
				default: r.aluOp = aluXor;
			endcase
		end
		opLui: begin
			r.rfWr = 1'b1;
			r.extOp = extUpper;
			r.wbSel = wbLui;
		end
		opLb, opLbu, opLh, opLhu, opLw: begin
			r.rfWr = 1'b1;
			r.dmRd = 1'b1;
			r.wbSel = wbMem;
			r.extOp = extSign;
			r.aluOp = aluAdd;
			case (op)
				opLb: r.dmSel = dmLoadByte;
				opLbu: r.dmSel = dmLoadByteU;
				opLh: r.dmSel = dmLoadHalf;
				opLhu: r.dmSel = dmLoadHalfU;
				default: r.dmSel = dmLoadWord;
			endcase
		end
		opSb, opSh, opSw: begin
			r.dmWr = 1'b1;
			r.extOp = extSign;
			r.aluOp = aluAdd;
			case (op)
				opSb: r.dmSel = dmStoreByte;
				opSh: r.dmSel = dmStoreHalf;
				default: r.dmSel = dmStoreWord;
			endcase
		end
		default: r.riExc = 1'b1;
	endcase
	if (isBranch) begin
		r.npcOp = taken ? npcBranch : npcSeq;
		r.likelyFlush = likely && !taken;  // Delay slot squashed
	end
	return r;
endfunction

`endif

//--- verif/decodeTb.sv
`timescale 1ns/100ps
`default_nettype none
`include "decode_macros.svh"

module decodeTb;

	import isaPkg::*;
	import ctrlPkg::*;

	`include "decodeModel.svh"

	localparam int aluItems = 60;
	localparam int memItems = 40;
	localparam int branchItems = 60;
	localparam int likelyItems = 40;
	localparam int reservedItems = 30;
	localparam int creditItems = 120;
	localparam int cycleLimit = 40 * (aluItems + memItems + branchItems + likelyItems
		+ reservedItems + creditItems);

	localparam logic [5:0] aluFuncts [16] = '{fnAdd, fnAddu, fnSub, fnSubu, fnAnd, fnOr,
		fnXor, fnNor, fnSlt, fnSltu, fnSllv, fnSrlv, fnSrav, fnSll, fnSrl, fnSra};
	localparam logic [5:0] immOps [8] = '{opAddi, opAddiu, opSlti, opSltiu, opAndi, opOri,
		opXori, opLui};
	localparam logic [5:0] memOps [8] = '{opLb, opLh, opLw, opLbu, opLhu, opSb, opSh, opSw};
	localparam logic [5:0] branchOps [8] = '{opBeq, opBne, opBlez, opBgtz, opRegimm, opJ,
		opJal, opSpecial};
	localparam logic [4:0] regimmSels [8] = '{rtBltz, rtBgez, rtBltzl, rtBgezl, rtBltzal,
		rtBgezal, rtBltzall, rtBgezall};
	localparam logic [5:0] likelyOps [4] = '{opBeql, opBnel, opBlezl, opBgtzl};

	logic clk;
	logic rst;
	logic inValid;
	instrWord_t inInstr;
	logic inCmpEq;
	logic [1:0] inCmpSign;
	logic outCredit;
	logic inCredit;
	logic outValid;
	logic rfWr;
	dstSel_t dstSel;
	wbSel_t wbSel;
	extOp_t extOp;
	aluOp_t aluOp;
	logic shamtSel;
	logic dmRd;
	logic dmWr;
	dmSel_t dmSel;
	npcOp_t npcOp;
	logic likelyFlush;
	logic riExc;

	logic [15:0] lfsr;
	expRec_t expQ [$];  // Scoreboard, oldest record first
	int cycleCount = 0;
	int inCredits;
	int accepted;
	int inCreditPulses;
	int received;
	int returned;
	int owed;  // Records seen whose credit is not yet returned
	int testErrors;
	int totalErrors;
	int testsPassed;
	int testsFailed;
	int creditMode;
	string testName;

	decodeTop DUT (.*);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	always @(posedge clk)
		cycleCount <= cycleCount + 1;

	function automatic logic [15:0] lfsrNext(input logic [15:0] s);
		return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
	endfunction

	function automatic logic [31:0] randBits(input int n);
		logic [31:0] v;
		int i;
		v = '0;
		for (i = 0; i < n; i++) begin
			v = {v[30:0], lfsr[0]};
			lfsr = lfsrNext(lfsr);
		end
		return v;
	endfunction

	// Group 5 mixes the other five
	function automatic logic [31:0] makeInstr(input int kind);
		logic [31:0] w;
		logic [2:0] pick;
		expRec_t probe;
		int group;
		group = (kind == 5) ? int'(randBits(3) % 5) : kind;
		w = randBits(32);  // Random register and immediate fields
		pick = 3'(randBits(3));
		case (group)
			0: begin
				if (randBits(1) != 0) begin
					w[31:26] = opSpecial;
					w[5:0] = aluFuncts[4'(randBits(4))];
				end else begin
					w[31:26] = immOps[pick];
				end
			end
			1: w[31:26] = memOps[pick];
			2: begin
				w[31:26] = branchOps[pick];
				if (pick == 3'd4)
					w[20:16] = regimmSels[3'(randBits(3))];
				if (pick == 3'd7)
					w[5:0] = (randBits(1) != 0) ? fnJalr : fnJr;
			end
			3: begin
				if (pick[2]) begin
					w[31:26] = opRegimm;
					w[20:16] = {pick[1], 3'b001, pick[0]};  // Likely regimm forms
				end else begin
					w[31:26] = likelyOps[pick[1:0]];
					if (randBits(1) != 0)
						w[20:16] = 5'd0;
				end
			end
			default: begin
				probe = decodeRef(w, 1'b0, 2'b00);
				while (!probe.riExc) begin
					w = randBits(32);
					probe = decodeRef(w, 1'b0, 2'b00);
				end
			end
		endcase
		return w;
	endfunction

	// Mode 1 returns credits in one window out of four
	function automatic logic creditWindow();
		logic [31:0] r;
		r = randBits(1);
		if (creditMode == 0)
			return r[0];
		else
			return (cycleCount[5:4] == 2'b11) && r[0];
	endfunction

	task automatic checkValue(input string what, input logic [31:0] expected,
		input logic [31:0] actual);
		if (actual !== expected) begin
			$display("FAIL %s %s expected %0h actual %0h", testName, what, expected, actual);
			testErrors++;
		end
	endtask

	task automatic compareRecord(input expRec_t e);
		checkValue("rfWr", e.rfWr, rfWr);
		checkValue("dstSel", e.dstSel, dstSel);
		checkValue("wbSel", e.wbSel, wbSel);
		checkValue("extOp", e.extOp, extOp);
		checkValue("aluOp", e.aluOp, aluOp);
		checkValue("shamtSel", e.shamtSel, shamtSel);
		checkValue("dmRd", e.dmRd, dmRd);
		checkValue("dmWr", e.dmWr, dmWr);
		checkValue("dmSel", e.dmSel, dmSel);
		checkValue("npcOp", e.npcOp, npcOp);
		checkValue("likelyFlush", e.likelyFlush, likelyFlush);
		checkValue("riExc", e.riExc, riExc);
	endtask

	task automatic sampleOutputs();
		@(negedge clk);
		if (inCredit) begin
			inCredits++;
			inCreditPulses++;
			if (inCredits > `INGRESS_DEPTH) begin
				$display("Error in %s: more input credits returned than buffer slots", testName);
				testErrors++;
			end
		end
		if (outValid) begin
			received++;
			owed++;
			if (received > returned + `OUT_CREDITS) begin
				$display("Error in %s: record %0d sent without a downstream credit",
					testName, received);
				testErrors++;
			end
			if (expQ.size() == 0) begin
				$display("Error in %s: record came out with no accepted item pending", testName);
				testErrors++;
			end else begin
				compareRecord(expQ.pop_front());
			end
		end
	endtask

	task automatic doCycle(input logic send, input logic [31:0] instr, input logic eq,
		input logic [1:0] sign);
		logic giveBack;
		sampleOutputs();
		giveBack = (owed > 0) && creditWindow();
		@(posedge clk);
		inValid <= send;
		inInstr <= instr;
		inCmpEq <= eq;
		inCmpSign <= sign;
		outCredit <= giveBack;
		if (giveBack) begin
			owed--;
			returned++;
		end
		if (send) begin
			expQ.push_back(decodeRef(instr, eq, sign));
			inCredits--;
			accepted++;
		end
	endtask

	task automatic sendItem(input logic [31:0] instr);
		logic eq;
		logic [1:0] sign;
		eq = 1'(randBits(1));
		sign = 2'(randBits(2));
		if (sign == 2'b11)
			sign = 2'b00;  // Only three sign classes
		while (inCredits == 0 || randBits(2) == 0)
			doCycle(1'b0, 32'd0, 1'b0, 2'b00);
		doCycle(1'b1, instr, eq, sign);
	endtask

	task automatic runTest(input string name, input int kind, input int items);
		int i;
		testName = name;
		testErrors = 0;
		for (i = 0; i < items; i++)
			sendItem(makeInstr(kind));
		while (expQ.size() != 0)
			doCycle(1'b0, 32'd0, 1'b0, 2'b00);
		repeat (8)
			doCycle(1'b0, 32'd0, 1'b0, 2'b00);  // Nothing more may come out
		checkValue("inCredit pulses", accepted, inCreditPulses);
		checkValue("records out", accepted, received);
		checkValue("input credits", `INGRESS_DEPTH, inCredits);
		totalErrors += testErrors;
		if (testErrors == 0) begin
			testsPassed++;
			$display("Test %s passed, %0d items", name, items);
		end else begin
			testsFailed++;
			$display("Test %s finished with %0d errors", name, testErrors);
		end
	endtask

	initial begin
		lfsr = 16'd93;
		inCredits = `INGRESS_DEPTH;
		accepted = 0;
		inCreditPulses = 0;
		received = 0;
		returned = 0;
		owed = 0;
		totalErrors = 0;
		testsPassed = 0;
		testsFailed = 0;
		creditMode = 0;
		testName = "reset";
		rst <= 1'b0;
		inValid <= 1'b0;
		inInstr <= '0;
		inCmpEq <= 1'b0;
		inCmpSign <= 2'b00;
		outCredit <= 1'b0;
		repeat (3) @(posedge clk);
		rst <= 1'b1;
		runTest("aluDecode", 0, aluItems);
		runTest("memDecode", 1, memItems);
		runTest("branchJump", 2, branchItems);
		runTest("likelyFlush", 3, likelyItems);
		runTest("reservedInstr", 4, reservedItems);
		creditMode = 1;  // Long stretches without downstream credits
		runTest("creditDiscipline", 5, creditItems);
		$display("Tests passed %0d, failed %0d, records checked %0d, errors %0d",
			testsPassed, testsFailed, received, totalErrors);
		if (totalErrors == 0)
			$display("Verification passed");
		else
			$display("Verification failed");
		$finish;
	end

	initial begin
		while (cycleCount < cycleLimit)
			@(negedge clk);
		$display("Timeout after %0d cycles in %s with %0d records still expected",
			cycleCount, testName, expQ.size());
		$display("Verification failed");
		$finish;
	end

endmodule

`default_nettype wire

//--- src/decodeTop.sv
`timescale 1ns/100ps
`default_nettype none

module decodeTop (
	input  logic clk,
	input  logic rst,
	input  logic inValid,
	input  isaPkg::instrWord_t inInstr,
	input  logic inCmpEq,
	input  logic [1:0] inCmpSign,
	input  logic outCredit,
	output logic inCredit,
	output logic outValid,
	output logic rfWr,
	output ctrlPkg::dstSel_t dstSel,
	output ctrlPkg::wbSel_t wbSel,
	output ctrlPkg::extOp_t extOp,
	output ctrlPkg::aluOp_t aluOp,
	output logic shamtSel,
	output logic dmRd,
	output logic dmWr,
	output ctrlPkg::dmSel_t dmSel,
	output ctrlPkg::npcOp_t npcOp,
	output logic likelyFlush,
	output logic riExc
);

	import isaPkg::*;
	import ctrlPkg::*;

	issueWord_t inWord;
	issueWord_t issueData;
	logic ingressNotEmpty;
	logic issue;
	logic issueRoom;

	// Stage one outputs
	logic s1Valid;
	logic s1RfWr;
	dstSel_t s1Dst;
	wbSel_t s1Wb;
	extOp_t s1Ext;
	aluOp_t s1AluOp;
	logic s1ShamtSel;
	logic s1DmRd;
	logic s1DmWr;
	dmSel_t s1DmSel;
	logic s1RiExc;
	brClass_t s1BrClass;
	logic s1Likely;
	jType_t s1JType;
	logic s1CmpEq;
	logic [1:0] s1CmpSign;
	logic s1RtZero;

	logic stageValid;
	ctrlWord_t stageWord;

	assign inWord = '{instr: inInstr, cmpEq: inCmpEq, cmpSign: inCmpSign};
	assign issue = ingressNotEmpty && issueRoom;

	creditFifo #(
		.payload_t(issueWord_t)
	) ingressBuf (
		.clk(clk),
		.rst(rst),
		.push(inValid),
		.pushData(inWord),
		.pop(issue),
		.popData(issueData),
		.notEmpty(ingressNotEmpty),
		.count()
	);

	fieldDecoder stage1 (.*);

	branchResolver stage2 (.*);

	ctrlEgress egress (.*);

	// One credit back upstream per freed ingress slot
	always_ff @(posedge clk) begin
		if (!rst)
			inCredit <= 1'b0;
		else
			inCredit <= issue;
	end

endmodule

`default_nettype wire

//--- src/ctrlEgress.sv
`timescale 1ns/100ps
`default_nettype none
`include "decode_macros.svh"

module ctrlEgress (
	input  logic clk,
	input  logic rst,
	input  logic issue,
	input  logic stageValid,
	input  ctrlPkg::ctrlWord_t stageWord,
	input  logic outCredit,
	output logic issueRoom,
	output logic outValid,
	output logic rfWr,
	output ctrlPkg::dstSel_t dstSel,
	output ctrlPkg::wbSel_t wbSel,
	output ctrlPkg::extOp_t extOp,
	output ctrlPkg::aluOp_t aluOp,
	output logic shamtSel,
	output logic dmRd,
	output logic dmWr,
	output ctrlPkg::dmSel_t dmSel,
	output ctrlPkg::npcOp_t npcOp,
	output logic likelyFlush,
	output logic riExc
);

	import ctrlPkg::*;

	ctrlWord_t headWord;
	logic notEmpty;
	logic [2:0] count;
	logic [2:0] credits;
	logic [2:0] inFlight;  // Issued but not yet in the buffer
	logic send;

	creditFifo #(
		.payload_t(ctrlWord_t),
		.depth(`EGRESS_DEPTH)
	) recordBuf (
		.clk(clk),
		.rst(rst),
		.push(stageValid),
		.pushData(stageWord),
		.pop(send),
		.popData(headWord),
		.notEmpty(notEmpty),
		.count(count)
	);

	assign send = notEmpty && (credits != 3'd0);
	assign issueRoom = (4'(count) + 4'(inFlight)) < 4'(`EGRESS_DEPTH);

	always_ff @(posedge clk) begin
		if (!rst) begin
			credits <= 3'(`OUT_CREDITS);
			inFlight <= 3'd0;
			outValid <= 1'b0;
		end else begin
			case ({send, outCredit})
				2'b10: credits <= credits - 3'd1;
				2'b01: credits <= credits + 3'd1;
				default: credits <= credits;
			endcase
			case ({issue, stageValid})
				2'b10: inFlight <= inFlight + 3'd1;
				2'b01: inFlight <= inFlight - 3'd1;
				default: inFlight <= inFlight;
			endcase
			outValid <= send;
		end
	end

	always_ff @(posedge clk) begin
		if (send) begin
			rfWr <= headWord.rfWr;
			dstSel <= headWord.dstSel;
			wbSel <= headWord.wbSel;
			extOp <= headWord.extOp;
			aluOp <= headWord.aluOp;
			shamtSel <= headWord.shamtSel;
			dmRd <= headWord.dmRd;
			dmWr <= headWord.dmWr;
			dmSel <= headWord.dmSel;
			npcOp <= headWord.npcOp;
			likelyFlush <= headWord.likelyFlush;
			riExc <= headWord.riExc;
		end
	end

	// Downstream returns only what it was given
	creditBound: assert property (@(posedge clk) disable iff (!rst)
		credits <= 3'(`OUT_CREDITS))
		else $error("ctrlEgress credit overflow");

endmodule

`default_nettype wire

//--- src/branchResolver.sv
`timescale 1ns/100ps
`default_nettype none

module branchResolver (
	input  logic clk,
	input  logic rst,
	input  logic s1Valid,
	input  logic s1RfWr,
	input  ctrlPkg::dstSel_t s1Dst,
	input  ctrlPkg::wbSel_t s1Wb,
	input  ctrlPkg::extOp_t s1Ext,
	input  ctrlPkg::aluOp_t s1AluOp,
	input  logic s1ShamtSel,
	input  logic s1DmRd,
	input  logic s1DmWr,
	input  ctrlPkg::dmSel_t s1DmSel,
	input  logic s1RiExc,
	input  ctrlPkg::brClass_t s1BrClass,
	input  logic s1Likely,
	input  ctrlPkg::jType_t s1JType,
	input  logic s1CmpEq,
	input  logic [1:0] s1CmpSign,
	input  logic s1RtZero,
	output logic stageValid,
	output ctrlPkg::ctrlWord_t stageWord
);

	import isaPkg::*;
	import ctrlPkg::*;

	logic condMet;
	logic taken;
	npcOp_t npcOp;

	always_comb begin
		case (s1BrClass)
			brEq: condMet = s1CmpEq;
			brNe: condMet = !s1CmpEq;
			brGez: condMet = (s1CmpSign != signNeg);
			brLtz: condMet = (s1CmpSign == signNeg);
			brLez: condMet = (s1CmpSign != signPos);
			brGtz: condMet = (s1CmpSign == signPos);
			default: condMet = 1'b0;
		endcase
	end

	assign taken = condMet && s1RtZero;  // BLEZL and BGTZL need rt zero

	always_comb begin
		if (s1BrClass != brNone)
			npcOp = taken ? npcBranch : npcSeq;
		else if (s1JType == jDirect)
			npcOp = npcJump;
		else if (s1JType == jReg)
			npcOp = npcJumpReg;
		else
			npcOp = npcSeq;
	end

	always_ff @(posedge clk) begin
		if (!rst)
			stageValid <= 1'b0;
		else
			stageValid <= s1Valid;
	end

	always_ff @(posedge clk) begin
		if (s1Valid) begin
			stageWord.rfWr <= s1RfWr;
			stageWord.dstSel <= s1Dst;
			stageWord.wbSel <= s1Wb;
			stageWord.extOp <= s1Ext;
			stageWord.aluOp <= s1AluOp;
			stageWord.shamtSel <= s1ShamtSel;
			stageWord.dmRd <= s1DmRd;
			stageWord.dmWr <= s1DmWr;
			stageWord.dmSel <= s1DmSel;
			stageWord.npcOp <= npcOp;
			stageWord.likelyFlush <= s1Likely && !taken;  // Squash the delay slot
			stageWord.riExc <= s1RiExc;
		end
	end

	// A reserved word never redirects the PC
	seqOnReserved: assert property (@(posedge clk) disable iff (!rst)
		stageValid && stageWord.riExc |-> stageWord.npcOp == npcSeq)
		else $error("branchResolver redirect on reserved record");

endmodule

`default_nettype wire

//--- src/fieldDecoder.sv
`timescale 1ns/100ps
`default_nettype none
`include "decode_macros.svh"

module fieldDecoder (
	input  logic clk,
	input  logic rst,
	input  logic issue,
	input  isaPkg::issueWord_t issueData,
	output logic s1Valid,
	output logic s1RfWr,
	output ctrlPkg::dstSel_t s1Dst,
	output ctrlPkg::wbSel_t s1Wb,
	output ctrlPkg::extOp_t s1Ext,
	output ctrlPkg::aluOp_t s1AluOp,
	output logic s1ShamtSel,
	output logic s1DmRd,
	output logic s1DmWr,
	output ctrlPkg::dmSel_t s1DmSel,
	output logic s1RiExc,
	output ctrlPkg::brClass_t s1BrClass,
	output logic s1Likely,
	output ctrlPkg::jType_t s1JType,
	output logic s1CmpEq,
	output logic [1:0] s1CmpSign,
	output logic s1RtZero
);

	import isaPkg::*;
	import ctrlPkg::*;

	opcode_t op;
	funct_t fn;
	regIdx_t rt;
	logic rfWr;
	dstSel_t dst;
	wbSel_t wb;
	extOp_t ext;
	aluOp_t aluOp;
	logic shamtSel;
	logic dmRd;
	logic dmWr;
	dmSel_t dmSel;
	logic riExc;
	brClass_t brClass;
	logic likely;
	jType_t jType;
	logic rtZero;

	assign op = issueData.instr[`OP_FIELD];
	assign fn = issueData.instr[`FUNCT_FIELD];
	assign rt = issueData.instr[`RT_FIELD];

	always_comb begin
		rfWr = 1'b0;
		dst = dstRt;
		wb = wbAlu;
		ext = extZero;
		aluOp = aluNone;
		shamtSel = 1'b0;
		dmRd = 1'b0;
		dmWr = 1'b0;
		dmSel = dmLoadWord;
		riExc = 1'b1;  // Cleared by every kept instruction
		brClass = brNone;
		likely = 1'b0;
		jType = jNone;
		rtZero = 1'b1;
		case (op)
			opSpecial: begin
				riExc = 1'b0;
				rfWr = 1'b1;
				dst = dstRd;
				case (fn)
					fnAdd: aluOp = aluAdd;
					fnAddu: aluOp = aluAddu;
					fnSub: aluOp = aluSub;
					fnSubu: aluOp = aluSubu;
					fnAnd: aluOp = aluAnd;
					fnOr: aluOp = aluOr;
					fnXor: aluOp = aluXor;
					fnNor: aluOp = aluNor;
					fnSlt: aluOp = aluSlt;
					fnSltu: aluOp = aluSltu;
					fnSllv: aluOp = aluSll;
					fnSrlv: aluOp = aluSrl;
					fnSrav: aluOp = aluSra;
					fnSll, fnSrl, fnSra: begin
						shamtSel = 1'b1;  // Shift amount from the shamt field
						aluOp = (fn == fnSll) ? aluSll : (fn == fnSrl) ? aluSrl : aluSra;
					end
					fnJr: begin
						rfWr = 1'b0;
						jType = jReg;
					end
					fnJalr: begin
						wb = wbLink;
						jType = jReg;
					end
					default: begin
						riExc = 1'b1;
						rfWr = 1'b0;
						dst = dstRt;
					end
				endcase
			end
			opRegimm: begin
				case (rt)
					rtBltz, rtBltzl, rtBltzal, rtBltzall: brClass = brLtz;
					rtBgez, rtBgezl, rtBgezal, rtBgezall: brClass = brGez;
					default: brClass = brNone;
				endcase
				if (brClass != brNone) begin
					riExc = 1'b0;
					dst = dstR31;
					wb = wbLink;
					likely = rt[1];
					rfWr = rt[4];  // Linking forms
				end
			end
			opJ: begin
				riExc = 1'b0;
				jType = jDirect;
			end
			opJal: begin
				riExc = 1'b0;
				jType = jDirect;
				rfWr = 1'b1;
				dst = dstR31;
				wb = wbLink;
			end
			opBeq, opBeql: begin
				riExc = 1'b0;
				brClass = brEq;
				likely = (op == opBeql);
			end
			opBne, opBnel: begin
				riExc = 1'b0;
				brClass = brNe;
				likely = (op == opBnel);
			end
			opBlez, opBgtz: begin
				riExc = 1'b0;
				brClass = (op == opBlez) ? brLez : brGtz;
			end
			opBlezl, opBgtzl: begin
				// Only legal with rt zero, but the flush still applies
				brClass = (op == opBlezl) ? brLez : brGtz;
				likely = 1'b1;
				rtZero = (rt == 5'd0);
				riExc = (rt != 5'd0);
			end
			opAddi, opAddiu, opSlti, opSltiu: begin
				riExc = 1'b0;
				rfWr = 1'b1;
				ext = extSign;
				case (op)
					opAddi: aluOp = aluAdd;
					opAddiu: aluOp = aluAddu;
					opSlti: aluOp = aluSlt;
					default: aluOp = aluSltu;
				endcase
			end
			opAndi, opOri, opXori: begin
				riExc = 1'b0;
				rfWr = 1'b1;
				aluOp = (op == opAndi) ? aluAnd : (op == opOri) ? aluOr : aluXor;
			end
			opLui: begin
				riExc = 1'b0;
				rfWr = 1'b1;
				ext = extUpper;
				wb = wbLui;
			end
			opLb, opLbu, opLh, opLhu, opLw: begin
				riExc = 1'b0;
				rfWr = 1'b1;
				dmRd = 1'b1;
				wb = wbMem;
				ext = extSign;
				aluOp = aluAdd;  // Base plus offset
				case (op)
					opLb: dmSel = dmLoadByte;
					opLbu: dmSel = dmLoadByteU;
					opLh: dmSel = dmLoadHalf;
					opLhu: dmSel = dmLoadHalfU;
					default: dmSel = dmLoadWord;
				endcase
			end
			opSb, opSh, opSw: begin
				riExc = 1'b0;
				dmWr = 1'b1;
				ext = extSign;
				aluOp = aluAdd;
				dmSel = (op == opSb) ? dmStoreByte : (op == opSh) ? dmStoreHalf : dmStoreWord;
			end
			default: riExc = 1'b1;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rst)
			s1Valid <= 1'b0;
		else
			s1Valid <= issue;
	end

	always_ff @(posedge clk) begin
		if (issue) begin
			s1RfWr <= rfWr;
			s1Dst <= dst;
			s1Wb <= wb;
			s1Ext <= ext;
			s1AluOp <= aluOp;
			s1ShamtSel <= shamtSel;
			s1DmRd <= dmRd;
			s1DmWr <= dmWr;
			s1DmSel <= dmSel;
			s1RiExc <= riExc;
			s1BrClass <= brClass;
			s1Likely <= likely;
			s1JType <= jType;
			s1CmpEq <= issueData.cmpEq;
			s1CmpSign <= issueData.cmpSign;
			s1RtZero <= rtZero;
		end
	end

endmodule

`default_nettype wire

//--- src/creditFifo.sv
`timescale 1ns/100ps
`default_nettype none
`include "decode_macros.svh"

module creditFifo #(
	parameter type payload_t = logic [31:0],
	parameter int depth = `INGRESS_DEPTH
) (
	input  logic clk,
	input  logic rst,
	input  logic push,
	input  payload_t pushData,
	input  logic pop,
	output payload_t popData,
	output logic notEmpty,
	output logic [2:0] count
);

	localparam int ptrBits = $clog2(depth);

	payload_t mem [depth];
	logic [ptrBits-1:0] wrPtr;
	logic [ptrBits-1:0] rdPtr;

	assign popData = mem[rdPtr];  // Head is visible before the pop
	assign notEmpty = (count != 3'd0);

	always_ff @(posedge clk) begin
		if (push)
			mem[wrPtr] <= pushData;
	end

	always_ff @(posedge clk) begin
		if (!rst) begin
			wrPtr <= '0;
			rdPtr <= '0;
			count <= 3'd0;
		end else begin
			if (push)
				wrPtr <= (wrPtr == ptrBits'(depth - 1)) ? '0 : wrPtr + 1'b1;
			if (pop)
				rdPtr <= (rdPtr == ptrBits'(depth - 1)) ? '0 : rdPtr + 1'b1;
			case ({push, pop})
				2'b10: count <= count + 3'd1;
				2'b01: count <= count - 3'd1;
				default: count <= count;
			endcase
		end
	end

	// Writer side must honour its credits
	noOverflow: assert property (@(posedge clk) disable iff (!rst)
		push |-> (count < 3'(depth)))
		else $error("creditFifo push while full");

	noUnderflow: assert property (@(posedge clk) disable iff (!rst)
		pop |-> notEmpty)
		else $error("creditFifo pop while empty");

endmodule

`default_nettype wire

//--- src/ctrlPkg.sv
`default_nettype none

package ctrlPkg;

	typedef enum logic [4:0] {
		aluAdd = 5'b00000,
		aluSub = 5'b00001,
		aluOr = 5'b00010,
		aluAnd = 5'b00011,
		aluNor = 5'b00100,
		aluXor = 5'b00101,
		aluSll = 5'b00110,
		aluSrl = 5'b00111,
		aluSra = 5'b01000,
		aluSlt = 5'b01001,
		aluSltu = 5'b01010,
		aluAddu = 5'b01100,
		aluSubu = 5'b10000,
		aluNone = 5'b11111  // No ALU result needed
	} aluOp_t;

	typedef enum logic [1:0] {
		npcSeq = 2'b00,
		npcBranch = 2'b01,
		npcJump = 2'b10,
		npcJumpReg = 2'b11
	} npcOp_t;

	typedef enum logic [2:0] {
		wbLui = 3'b001,
		wbAlu = 3'b010,
		wbLink = 3'b011,
		wbMem = 3'b100
	} wbSel_t;

	typedef enum logic [1:0] {
		dstRt = 2'b00,
		dstRd = 2'b01,
		dstR31 = 2'b10
	} dstSel_t;

	typedef enum logic [1:0] {
		extZero = 2'b00,
		extSign = 2'b01,
		extUpper = 2'b10
	} extOp_t;

	typedef enum logic [2:0] {
		dmStoreByte = 3'b000,
		dmStoreHalf = 3'b001,
		dmStoreWord = 3'b010,
		dmLoadByteU = 3'b011,
		dmLoadByte = 3'b100,
		dmLoadHalfU = 3'b101,
		dmLoadHalf = 3'b110,
		dmLoadWord = 3'b111  // Also the idle value
	} dmSel_t;

	typedef enum logic [2:0] {
		brEq = 3'b000,
		brNe = 3'b001,
		brGez = 3'b010,
		brLtz = 3'b011,
		brLez = 3'b100,
		brGtz = 3'b101,
		brNone = 3'b111
	} brClass_t;

	typedef enum logic [1:0] {
		jNone = 2'b00,
		jDirect = 2'b01,  // J, JAL
		jReg = 2'b10      // JR, JALR
	} jType_t;

	typedef struct packed {
		logic rfWr;
		dstSel_t dstSel;
		wbSel_t wbSel;
		extOp_t extOp;
		aluOp_t aluOp;
		logic shamtSel;
		logic dmRd;
		logic dmWr;
		dmSel_t dmSel;
		npcOp_t npcOp;
		logic likelyFlush;
		logic riExc;
	} ctrlWord_t;

endpackage

`default_nettype wire

//--- src/isaPkg.sv
`default_nettype none

package isaPkg;

	typedef logic [5:0] opcode_t;
	typedef logic [5:0] funct_t;
	typedef logic [4:0] regIdx_t;
	typedef logic [31:0] instrWord_t;

	// Instruction plus the compare flags from the register stage
	typedef struct packed {
		instrWord_t instr;
		logic cmpEq;          // High when the operands are equal
		logic [1:0] cmpSign;  // Sign class of rs
	} issueWord_t;

	localparam logic [1:0] signNeg = 2'b10;
	localparam logic [1:0] signPos = 2'b01;

	localparam opcode_t opSpecial = 6'b000000;
	localparam opcode_t opRegimm = 6'b000001;
	localparam opcode_t opJ = 6'b000010;
	localparam opcode_t opJal = 6'b000011;
	localparam opcode_t opBeq = 6'b000100;
	localparam opcode_t opBne = 6'b000101;
	localparam opcode_t opBlez = 6'b000110;
	localparam opcode_t opBgtz = 6'b000111;
	localparam opcode_t opAddi = 6'b001000;
	localparam opcode_t opAddiu = 6'b001001;
	localparam opcode_t opSlti = 6'b001010;
	localparam opcode_t opSltiu = 6'b001011;
	localparam opcode_t opAndi = 6'b001100;
	localparam opcode_t opOri = 6'b001101;
	localparam opcode_t opXori = 6'b001110;
	localparam opcode_t opLui = 6'b001111;
	localparam opcode_t opBeql = 6'b010100;
	localparam opcode_t opBnel = 6'b010101;
	localparam opcode_t opBlezl = 6'b010110;
	localparam opcode_t opBgtzl = 6'b010111;
	localparam opcode_t opLb = 6'b100000;
	localparam opcode_t opLh = 6'b100001;
	localparam opcode_t opLw = 6'b100011;
	localparam opcode_t opLbu = 6'b100100;
	localparam opcode_t opLhu = 6'b100101;
	localparam opcode_t opSb = 6'b101000;
	localparam opcode_t opSh = 6'b101001;
	localparam opcode_t opSw = 6'b101011;

	localparam funct_t fnSll = 6'b000000;
	localparam funct_t fnSrl = 6'b000010;
	localparam funct_t fnSra = 6'b000011;
	localparam funct_t fnSllv = 6'b000100;
	localparam funct_t fnSrlv = 6'b000110;
	localparam funct_t fnSrav = 6'b000111;
	localparam funct_t fnJr = 6'b001000;
	localparam funct_t fnJalr = 6'b001001;
	localparam funct_t fnAdd = 6'b100000;
	localparam funct_t fnAddu = 6'b100001;
	localparam funct_t fnSub = 6'b100010;
	localparam funct_t fnSubu = 6'b100011;
	localparam funct_t fnAnd = 6'b100100;
	localparam funct_t fnOr = 6'b100101;
	localparam funct_t fnXor = 6'b100110;
	localparam funct_t fnNor = 6'b100111;
	localparam funct_t fnSlt = 6'b101010;
	localparam funct_t fnSltu = 6'b101011;

	// REGIMM selectors in the rt field
	localparam regIdx_t rtBltz = 5'b00000;
	localparam regIdx_t rtBgez = 5'b00001;
	localparam regIdx_t rtBltzl = 5'b00010;
	localparam regIdx_t rtBgezl = 5'b00011;
	localparam regIdx_t rtBltzal = 5'b10000;
	localparam regIdx_t rtBgezal = 5'b10001;
	localparam regIdx_t rtBltzall = 5'b10010;
	localparam regIdx_t rtBgezall = 5'b10011;

endpackage

`default_nettype wire

//--- src/decode_macros.svh
`ifndef DECODE_MACROS_SVH
`define DECODE_MACROS_SVH

// Ingress buffer depth, also the credits the upstream holds after reset
`define INGRESS_DEPTH 4

`define EGRESS_DEPTH 4

// Credits the downstream grants after reset
`define OUT_CREDITS 3

// Registered stages between the two buffers
`define PIPE_STAGES 2

// Instruction field positions
`define OP_FIELD 31:26
`define RT_FIELD 20:16
`define FUNCT_FIELD 5:0

`endif
